// File: flist.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_tag_mem.sv
logic/dcache_data_mem.sv
logic/dcache_lookup.sv
logic/dcache_load_align.sv
logic/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

// File: logic/dcache_cfg.svh
// Geometry of the two-way data cache.
// Address and data are both 32 bits; lines are 32 bytes.
// The way count is fixed at two, and tag ops pick the way with the
// lowest tag bit of the address.
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and data width
`define DC_ADDR_W 32

// byte offset inside a line in bits 4:0
`define DC_OFF_W 5

// line index in bits 13:5
`define DC_IDX_W 9

// tag in bits 31:14
`define DC_TAG_W 18

// data array word index in bits 13:2
`define DC_WIDX_W 12

`define DC_WAYS 2
`define DC_WAY_BIT (`DC_OFF_W + `DC_IDX_W)
`define DC_LINES (1 << `DC_IDX_W)
`define DC_WORDS (1 << `DC_WIDX_W)

`endif

// File: logic/dcache_data_mem.sv
// Data RAM. Each entry packs the same word of both ways.
// Way0 sits in bits 31:0 and way1 in bits 63:32.
// Separate read and write ports; a read and a write to the same
// entry in one cycle returns the old contents.
// Array and read register start unknown after power-up.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_data_mem (
  input  logic                        clk_i,
  input  logic                        re_i,
  input  logic [`DC_WIDX_W-1:0]       ridx_i,
  output logic [2*`DC_ADDR_W-1:0]     rdata_o,
  input  logic                        we_i,
  input  logic [`DC_WIDX_W-1:0]       widx_i,
  input  logic [2*`DC_ADDR_W/8-1:0]   wmask_i,
  input  logic [2*`DC_ADDR_W-1:0]     wdata_i
);

  localparam int BYTES = 2 * `DC_ADDR_W / 8;

  logic [2*`DC_ADDR_W-1:0] mem [`DC_WORDS];

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < BYTES; b++) begin
        if (wmask_i[b]) begin
          mem[widx_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem[ridx_i];
    end
  end

endmodule

// File: logic/dcache_load_align.sv
// Combinational result-stage data path.
// Way1 wins whenever it hits, otherwise way0 is used.
// A load miss gives miss_o high with zero data; there is no refill.
// Ops other than LD, TAGLV and TAGLA drive zero on both outputs.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_load_align (
  input  dcache_pkg::dc_req_s        req_i,
  input  logic [2*`DC_ADDR_W-1:0]    rdata_i,
  input  logic                       hit0_i,
  input  logic                       hit1_i,
  input  logic [`DC_ADDR_W-1:0]      tagop_val_i,
  output logic [`DC_ADDR_W-1:0]      data_o,
  output logic                       miss_o
);
  import dcache_pkg::*;

  logic [`DC_ADDR_W-1:0] word_sel;
  logic [15:0]           half_sel;
  logic [7:0]            byte_sel;
  logic                  no_hit;

  assign word_sel = hit1_i ? rdata_i[2*`DC_ADDR_W-1:`DC_ADDR_W] : rdata_i[`DC_ADDR_W-1:0];
  assign half_sel = req_i.addr[1] ? word_sel[31:16] : word_sel[15:0];
  assign byte_sel = word_sel[8*req_i.addr[1:0] +: 8];
  assign no_hit   = !hit0_i && !hit1_i;

  always_comb begin
    data_o = '0;
    miss_o = 1'b0;
    case (req_i.op)
      DC_OP_LD: begin
        miss_o = no_hit;
        if (!no_hit) begin
          case (req_i.size)
            DC_SZ_BYTE: begin
              data_o = {{(`DC_ADDR_W-8){req_i.sigext & byte_sel[7]}}, byte_sel};
            end
            DC_SZ_HALF: begin
              data_o = {{(`DC_ADDR_W-16){req_i.sigext & half_sel[15]}}, half_sel};
            end
            default: begin
              data_o = word_sel;
            end
          endcase
        end
      end
      DC_OP_TAGLV, DC_OP_TAGLA: begin
        data_o = tagop_val_i;
      end
      default: begin
        data_o = '0;
      end
    endcase
  end

endmodule

// File: logic/dcache_lookup.sv
// Combinational tag-lookup stage logic.
// Hits are reported for every op; the top only acts on them for
// LD and ST. Both ways may hit at once, and later stages then
// prefer way1.
// Tag ops pick the way with address bit 14, not by compare.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_lookup (
  input  dcache_pkg::dc_req_s      req_i,
  input  dcache_pkg::dc_tag_pair_s tags_i,
  output logic                     hit0_o,
  output logic                     hit1_o,
  output logic [`DC_ADDR_W-1:0]    tagop_val_o
);
  import dcache_pkg::*;

  logic [`DC_TAG_W-1:0] addr_tag;
  logic [`DC_IDX_W-1:0] addr_idx;
  logic                 way_sel;
  dc_tag_s              sel_tag;

  assign addr_tag = req_i.addr[`DC_WAY_BIT +: `DC_TAG_W];
  assign addr_idx = req_i.addr[`DC_OFF_W +: `DC_IDX_W];
  assign way_sel  = req_i.addr[`DC_WAY_BIT];

  assign hit0_o = tags_i.way0.valid && (tags_i.way0.tag == addr_tag);
  assign hit1_o = tags_i.way1.valid && (tags_i.way1.tag == addr_tag);

  // explicit way for TAGLV / TAGLA
  assign sel_tag = way_sel ? tags_i.way1 : tags_i.way0;

  always_comb begin
    case (req_i.op)
      DC_OP_TAGLV: begin
        tagop_val_o = {{(`DC_ADDR_W-1){1'b0}}, sel_tag.valid};
      end
      DC_OP_TAGLA: begin
        // rebuild the line address with zero offset bits
        tagop_val_o = {sel_tag.tag, addr_idx, {`DC_OFF_W{1'b0}}};
      end
      default: begin
        tagop_val_o = '0;
      end
    endcase
  end

endmodule

// File: logic/dcache_pkg.sv
// Types shared by the data cache blocks.
// Opcode values keep the fixed cache encoding; codes that are not
// listed act as a no-op that never returns a response.
`include "dcache_cfg.svh"

package dcache_pkg;

  typedef enum logic [3:0] {
    DC_OP_LD    = 4'h0,
    DC_OP_ST    = 4'h1,
    DC_OP_TAGST = 4'h2,
    DC_OP_TAGLV = 4'h4,
    DC_OP_TAGLA = 4'h5,
    // idles the result stage
    DC_OP_NOP   = 4'hf
  } dc_op_e;

  typedef enum logic [1:0] {
    DC_SZ_BYTE = 2'd0,
    DC_SZ_HALF = 2'd1,
    DC_SZ_WORD = 2'd2
  } dc_size_e;

  // one request as it travels down the pipe
  typedef struct packed {
    dc_op_e                op;
    dc_size_e              size;
    logic                  sigext;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_ADDR_W-1:0] data;
  } dc_req_s;

  typedef struct packed {
    logic                 valid;
    logic [`DC_TAG_W-1:0] tag;
  } dc_tag_s;

  // both ways of one line with way1 on top
  typedef struct packed {
    dc_tag_s way1;
    dc_tag_s way0;
  } dc_tag_pair_s;

endpackage

// File: logic/dcache_tag_mem.sv
// Tag RAM, one entry per line holding both ways.
// Single port. A write takes the port for that cycle and leaves the
// read register untouched, so rdata_o keeps the last read pair.
// Contents are unknown after power-up; software sets them with TAGST.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tag_mem (
  input  logic                     clk_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [`DC_WAYS-1:0]      way_mask_i,
  input  logic [`DC_IDX_W-1:0]     idx_i,
  input  dcache_pkg::dc_tag_s      wdata_i,
  output dcache_pkg::dc_tag_pair_s rdata_o
);
  import dcache_pkg::*;

  dc_tag_pair_s mem [`DC_LINES];

  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      if (way_mask_i[0]) begin
        mem[idx_i].way0 <= wdata_i;
      end
      if (way_mask_i[1]) begin
        mem[idx_i].way1 <= wdata_i;
      end
    end
  end

  // registered read, held until the next read
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

// File: logic/dcache_top.sv
// Two-way data cache core with software-managed tags.
// Pipe stages are accept, tl (tag compare) and v (result).
// There is no refill path. A load miss returns miss_o with zero data
// and a store miss is dropped.
// Stores write the data array as they leave v; a load waits while a
// store is in tl or v, which keeps load-after-store order.
// ready_o depends combinationally on v_i and instr_op_i.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    v_i,
  input  dcache_pkg::dc_op_e      instr_op_i,
  input  dcache_pkg::dc_size_e    size_op_i,
  input  logic                    sigext_op_i,
  input  logic [`DC_ADDR_W-1:0]   addr_i,
  input  logic [`DC_ADDR_W-1:0]   data_i,
  output logic                    ready_o,
  output logic                    v_o,
  output logic [`DC_ADDR_W-1:0]   data_o,
  output logic                    miss_o,
  input  logic                    yumi_i
);
  import dcache_pkg::*;

  dc_req_s req_a;
  dc_req_s req_tl;
  dc_req_s req_v;
  dc_req_s req_v_out;
  logic    v_tl_r;
  logic    v_v_r;

  logic accept;
  logic adv_v;
  logic hazard;
  logic ld_a;
  logic tagst_a;
  logic reads_tags_a;
  logic st_tl;
  logic st_v;
  logic returns_v;

  dc_tag_pair_s            tags_tl;
  logic [2*`DC_ADDR_W-1:0] rdata_tl;
  logic [2*`DC_ADDR_W-1:0] rdata_v;
  logic                    hit0_tl;
  logic                    hit1_tl;
  logic                    hit0_v;
  logic                    hit1_v;
  logic [`DC_ADDR_W-1:0]   tagop_tl;
  logic [`DC_ADDR_W-1:0]   tagop_v;

  logic [3:0]              st_mask;
  logic [`DC_ADDR_W-1:0]   st_data;
  logic                    st_we;
  dc_tag_s                 tag_wdata;

  assign req_a = '{op: instr_op_i, size: size_op_i, sigext: sigext_op_i,
                   addr: addr_i, data: data_i};

  // decode
  assign ld_a         = (instr_op_i == DC_OP_LD);
  assign tagst_a      = (instr_op_i == DC_OP_TAGST);
  assign reads_tags_a = ld_a || (instr_op_i == DC_OP_ST) ||
                        (instr_op_i == DC_OP_TAGLV) || (instr_op_i == DC_OP_TAGLA);
  assign st_tl        = v_tl_r && (req_tl.op == DC_OP_ST);
  assign st_v         = v_v_r && (req_v.op == DC_OP_ST);
  assign returns_v    = (req_v.op == DC_OP_LD) || (req_v.op == DC_OP_TAGLV) ||
                        (req_v.op == DC_OP_TAGLA);

  // handshakes
  assign adv_v   = !v_v_r || !returns_v || yumi_i;
  assign hazard  = v_i && ld_a && (st_tl || st_v);
  assign ready_o = (!v_tl_r || adv_v) && !hazard;
  assign accept  = v_i && ready_o;
  assign v_o     = v_v_r && returns_v;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      v_tl_r <= 1'b0;
      v_v_r  <= 1'b0;
    end else begin
      if (ready_o || adv_v) begin
        v_tl_r <= accept;
      end
      if (adv_v) begin
        v_v_r <= v_tl_r;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_tl <= req_a;
    end
    if (adv_v && v_tl_r) begin
      req_v   <= req_tl;
      hit0_v  <= hit0_tl;
      hit1_v  <= hit1_tl;
      tagop_v <= tagop_tl;
      rdata_v <= rdata_tl;
    end
  end

  // TAGST payload carries valid in bit 31 and the tag in the low bits
  assign tag_wdata = '{valid: data_i[`DC_ADDR_W-1], tag: data_i[`DC_TAG_W-1:0]};

  dcache_tag_mem i_tag_mem (
    .clk_i      (clk_i),
    .en_i       (accept && !rst_i && (reads_tags_a || tagst_a)),
    .we_i       (tagst_a),
    .way_mask_i ({addr_i[`DC_WAY_BIT], !addr_i[`DC_WAY_BIT]}),
    .idx_i      (addr_i[`DC_OFF_W +: `DC_IDX_W]),
    .wdata_i    (tag_wdata),
    .rdata_o    (tags_tl)
  );

  // store lanes by size and low address bits
  always_comb begin
    case (req_v.size)
      DC_SZ_BYTE: begin
        st_mask = 4'b0001 << req_v.addr[1:0];
        st_data = {4{req_v.data[7:0]}};
      end
      DC_SZ_HALF: begin
        st_mask = req_v.addr[1] ? 4'b1100 : 4'b0011;
        st_data = {2{req_v.data[15:0]}};
      end
      default: begin
        st_mask = 4'b1111;
        st_data = req_v.data;
      end
    endcase
  end

  // only a hitting store writes and way1 wins a double hit
  assign st_we = st_v && adv_v && (hit0_v || hit1_v);

  dcache_data_mem i_data_mem (
    .clk_i   (clk_i),
    .re_i    (accept && !rst_i && ld_a),
    .ridx_i  (addr_i[2 +: `DC_WIDX_W]),
    .rdata_o (rdata_tl),
    .we_i    (st_we),
    .widx_i  (req_v.addr[2 +: `DC_WIDX_W]),
    .wmask_i (hit1_v ? {st_mask, 4'b0000} : {4'b0000, st_mask}),
    .wdata_i ({2{st_data}})
  );

  dcache_lookup i_lookup (
    .req_i       (req_tl),
    .tags_i      (tags_tl),
    .hit0_o      (hit0_tl),
    .hit1_o      (hit1_tl),
    .tagop_val_o (tagop_tl)
  );

  // empty v stage looks like a no-op to the result path
  always_comb begin
    req_v_out = req_v;
    if (!v_v_r) begin
      req_v_out.op = DC_OP_NOP;
    end
  end

  dcache_load_align i_load_align (
    .req_i       (req_v_out),
    .rdata_i     (rdata_v),
    .hit0_i      (hit0_v),
    .hit1_i      (hit1_v),
    .tagop_val_i (tagop_v),
    .data_o      (data_o),
    .miss_o      (miss_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dcache_sim

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module dcache_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: verif/dcache_props.sv
// Output handshake assertions for the cache top level.
// Bound into every dcache_top instance; ready_o is not checked here.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_props (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  out_v_i,
  input logic                  yumi_i,
  input logic [`DC_ADDR_W-1:0] out_data_i,
  input logic                  out_miss_i
);

  // pipe is empty once reset has been seen
  assert_idle_after_reset: assert property (
    @(posedge clk_i) rst_i |=> !out_v_i
  ) else $error("v_o high in the cycle after reset");

  // a stalled response must not change
  assert_hold_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (out_v_i && !yumi_i) |=> (out_v_i && $stable(out_data_i) && $stable(out_miss_i))
  ) else $error("response changed or dropped while yumi_i was low");

  assert_miss_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    out_miss_i |-> out_v_i
  ) else $error("miss_o high while v_o is low");

endmodule

bind dcache_top dcache_props i_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .out_v_i    (v_o),
  .yumi_i     (yumi_i),
  .out_data_i (data_o),
  .out_miss_i (miss_o)
);

// File: verif/dcache_tb.sv
// Random testbench for the two-way data cache core.
// Both RAMs power up unknown, so a fixed setup sequence first tags
// every line used and fills every data word with word stores.
// Addresses stay on 4 lines and 3 tags so hits are frequent.
// The model applies each op at its accept edge and queues the responses.
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
  import dcache_pkg::*;

  localparam int          CLK_PERIOD = 4;
  localparam int          NUM_OPS    = 2000;
  localparam int          INIT_OPS   = 72;
  localparam int unsigned SEED       = 32'h33fd8a44;
  localparam int          TIMEOUT_NS = (NUM_OPS + INIT_OPS) * 20 * CLK_PERIOD;

  localparam logic [`DC_IDX_W-1:0] LINES [4] = '{9'h003, 9'h0a4, 9'h130, 9'h1ff};
  // lowest bit picks the way for tag ops
  localparam logic [`DC_TAG_W-1:0] TAGS [3] = '{18'h12340, 18'h0abc1, 18'h3ff02};

  logic                  clk_i;
  logic                  rst_i;
  logic                  v_i;
  dc_op_e                instr_op_i;
  dc_size_e              size_op_i;
  logic                  sigext_op_i;
  logic [`DC_ADDR_W-1:0] addr_i;
  logic [`DC_ADDR_W-1:0] data_i;
  logic                  ready_o;
  logic                  v_o;
  logic [`DC_ADDR_W-1:0] data_o;
  logic                  miss_o;
  logic                  yumi_i;

  // reference model state
  logic                  m_valid [2][`DC_LINES];
  logic [`DC_TAG_W-1:0]  m_tag   [2][`DC_LINES];
  logic [`DC_ADDR_W-1:0] m_data  [2][`DC_WORDS];

  dc_req_s     op_q [$];
  // op code, miss flag and data
  logic [36:0] exp_q [$];

  int n_returning;
  int n_checks;
  int n_data_err;
  int n_miss_err;
  int n_proto_err;

  dcache_top i_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .v_i         (v_i),
    .instr_op_i  (instr_op_i),
    .size_op_i   (size_op_i),
    .sigext_op_i (sigext_op_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .ready_o     (ready_o),
    .v_o         (v_o),
    .data_o      (data_o),
    .miss_o      (miss_o),
    .yumi_i      (yumi_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic dc_req_s make_req(dc_op_e op, dc_size_e size, logic sigext,
                                       logic [31:0] addr, logic [31:0] data);
    dc_req_s r;
    r.op     = op;
    r.size   = size;
    r.sigext = sigext;
    r.addr   = addr;
    r.data   = data;
    return r;
  endfunction

  function automatic dc_req_s random_req();
    dc_req_s     r;
    int unsigned pick;
    r.addr   = {TAGS[$urandom % 3], LINES[$urandom % 4], 5'($urandom)};
    r.size   = dc_size_e'($urandom % 3);
    r.sigext = 1'($urandom);
    r.data   = $urandom;
    pick     = $urandom % 100;
    if (pick < 35) r.op = DC_OP_LD;
    else if (pick < 65) r.op = DC_OP_ST;
    else if (pick < 75) r.op = DC_OP_TAGST;
    else if (pick < 83) r.op = DC_OP_TAGLV;
    else if (pick < 91) r.op = DC_OP_TAGLA;
    else r.op = DC_OP_NOP;
    // natural alignment for half and word
    if (r.size == DC_SZ_HALF) r.addr[0] = 1'b0;
    if (r.size == DC_SZ_WORD) r.addr[1:0] = 2'b00;
    if (r.op == DC_OP_TAGST) begin
      r.data[31] = ($urandom % 5) != 0;
      // mostly a tag the addresses use and sometimes a stray one
      r.data[`DC_TAG_W-1:0] = (($urandom % 8) != 0) ? TAGS[$urandom % 3] : 18'($urandom);
    end
    return r;
  endfunction

  task automatic build_stimulus();
    dc_req_s r;
    for (int l = 0; l < 4; l++) begin
      // way0 gets TAGS[0] and way1 gets TAGS[1]
      for (int t = 0; t < 2; t++) begin
        op_q.push_back(make_req(DC_OP_TAGST, DC_SZ_WORD, 1'b0, {TAGS[t], LINES[l], 5'd0},
                                {1'b1, 13'd0, TAGS[t]}));
      end
      for (int t = 0; t < 2; t++) begin
        for (int w = 0; w < 8; w++) begin
          op_q.push_back(make_req(DC_OP_ST, DC_SZ_WORD, 1'b0,
                                  {TAGS[t], LINES[l], 3'(w), 2'b00}, $urandom));
        end
      end
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      r = random_req();
      op_q.push_back(r);
      if (r.op == DC_OP_LD || r.op == DC_OP_TAGLV || r.op == DC_OP_TAGLA) n_returning++;
    end
  endtask

  function automatic logic [31:0] load_value(dc_req_s r, logic [31:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*r.addr[1:0] +: 8];
    h = word[16*r.addr[1] +: 16];
    if (r.size == DC_SZ_BYTE) return r.sigext ? 32'(signed'(b)) : 32'(b);
    if (r.size == DC_SZ_HALF) return r.sigext ? 32'(signed'(h)) : 32'(h);
    return word;
  endfunction

  task automatic apply_op(input dc_req_s r);
    logic [`DC_IDX_W-1:0]  idx;
    logic [`DC_WIDX_W-1:0] widx;
    logic                  sel;
    logic                  h0;
    logic                  h1;
    idx  = r.addr[13:5];
    widx = r.addr[13:2];
    sel  = r.addr[14];
    h0   = m_valid[0][idx] && (m_tag[0][idx] == r.addr[31:14]);
    h1   = m_valid[1][idx] && (m_tag[1][idx] == r.addr[31:14]);
    case (r.op)
      DC_OP_TAGST: begin
        m_valid[sel][idx] = r.data[31];
        m_tag[sel][idx]   = r.data[17:0];
      end
      DC_OP_TAGLV: exp_q.push_back({r.op, 1'b0, 31'd0, m_valid[sel][idx]});
      DC_OP_TAGLA: exp_q.push_back({r.op, 1'b0, m_tag[sel][idx], idx, 5'd0});
      DC_OP_LD: begin
        if (!h0 && !h1) exp_q.push_back({r.op, 1'b1, 32'd0});
        else exp_q.push_back({r.op, 1'b0, load_value(r, m_data[h1][widx])});
      end
      DC_OP_ST: begin
        // a missing store changes nothing
        if (h0 || h1) begin
          if (r.size == DC_SZ_BYTE) m_data[h1][widx][8*r.addr[1:0] +: 8] = r.data[7:0];
          else if (r.size == DC_SZ_HALF) m_data[h1][widx][16*r.addr[1] +: 16] = r.data[15:0];
          else m_data[h1][widx] = r.data;
        end
      end
      default: begin
      end
    endcase
  endtask

  function automatic string op_name(logic [3:0] code);
    if (code == DC_OP_LD) return "load";
    if (code == DC_OP_TAGLV) return "tag_valid_readback";
    if (code == DC_OP_TAGLA) return "tag_addr_readback";
    return "unknown_op";
  endfunction

  task automatic check_response(input logic [31:0] d, input logic m);
    logic [36:0] e;
    if (exp_q.size() == 0) begin
      n_proto_err++;
      $display("response with no request outstanding: data %h miss %b", d, m);
    end else begin
      e = exp_q.pop_front();
      n_checks++;
      if (d !== e[31:0]) begin
        n_data_err++;
        $display("[ERROR] %s data: expected %h actual %h", op_name(e[36:33]), e[31:0], d);
      end
      if (m !== e[32]) begin
        n_miss_err++;
        $display("[ERROR] %s miss: expected %b actual %b", op_name(e[36:33]), e[32], m);
      end
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run still busy after %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    dc_req_s     cur;
    logic        have;
    logic        acc;
    logic        con;
    logic [31:0] got_data;
    logic        got_miss;
    void'($urandom(SEED));
    rst_i       <= 1'b1;
    v_i         <= 1'b0;
    instr_op_i  <= DC_OP_NOP;
    size_op_i   <= DC_SZ_WORD;
    sigext_op_i <= 1'b0;
    addr_i      <= '0;
    data_i      <= '0;
    yumi_i      <= 1'b0;
    build_stimulus();
    cur  = make_req(DC_OP_NOP, DC_SZ_WORD, 1'b0, '0, '0);
    have = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    // idle pipe accepts right after reset
    @(negedge clk_i);
    if (ready_o !== 1'b1) begin
      n_proto_err++;
      $display("[ERROR] reset_idle ready_o: expected 1 actual %b", ready_o);
    end
    while (op_q.size() > 0 || have || exp_q.size() > 0) begin
      @(negedge clk_i);
      acc      = v_i && ready_o;
      con      = v_o && yumi_i;
      got_data = data_o;
      got_miss = miss_o;
      @(posedge clk_i);
      if (con) check_response(got_data, got_miss);
      if (acc) begin
        apply_op(cur);
        have = 1'b0;
      end
      if (!have && op_q.size() > 0 && ($urandom % 4) != 0) begin
        cur  = op_q.pop_front();
        have = 1'b1;
      end
      v_i         <= have;
      instr_op_i  <= cur.op;
      size_op_i   <= cur.size;
      sigext_op_i <= cur.sigext;
      addr_i      <= cur.addr;
      data_i      <= cur.data;
      yumi_i      <= ($urandom % 4) != 0;
    end
    v_i <= 1'b0;
    // stores still in flight must not raise v_o
    repeat (20) begin
      @(negedge clk_i);
      if (v_o) begin
        n_proto_err++;
        $display("v_o high after every response was consumed");
      end
    end
    if (n_checks != n_returning) begin
      n_proto_err++;
      $display("got %0d responses but %0d ops return data", n_checks, n_returning);
    end
    $display("checks %0d, data errors %0d, miss errors %0d, protocol errors %0d",
             n_checks, n_data_err, n_miss_err, n_proto_err);
    if (n_data_err == 0 && n_miss_err == 0 && n_proto_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
